/* rtl/memStage_settings.svh */
// Memory stage address map
`ifndef MEMSTAGE_SETTINGS_SVH
`define MEMSTAGE_SETTINGS_SVH

// Data memory window, end exclusive
`define DM_START      32'h0000_0000
`define DM_END        32'h0000_3000
`define DM_WORDS      3072

// Timer windows, end exclusive
`define TIMER0_START  32'h0000_7F00
`define TIMER0_END    32'h0000_7F0C
`define TIMER1_START  32'h0000_7F10
`define TIMER1_END    32'h0000_7F1C

// Read-only count registers
`define TIMER0_COUNT  32'h0000_7F08
`define TIMER1_COUNT  32'h0000_7F18

// Coprocessor 0
`define EPC_RESET     32'h0000_3000
`define PRID_VALUE    32'h0001_8001
`define CP0_SR        5'd12
`define CP0_CAUSE     5'd13
`define CP0_EPC       5'd14
`define CP0_PRID      5'd15

`endif

/* rtl/memStagePkg.sv */
// Memory stage shared types
package memStagePkg;

    // Operations seen by the memory stage
    typedef enum logic [3:0] {
        opNone = 4'd0,
        opLw   = 4'd1,
        opLh   = 4'd2,
        opLhu  = 4'd3,
        opLb   = 4'd4,
        opLbu  = 4'd5,
        opSw   = 4'd6,
        opSh   = 4'd7,
        opSb   = 4'd8,
        opMfc0 = 4'd9,
        opMtc0 = 4'd10,
        opEret = 4'd11
    } memOp;

    // Cause register exception code
    typedef logic [4:0] excCode;

    // Zero doubles as the interrupt code
    localparam excCode excNone  = 5'd0;
    localparam excCode excAdEL  = 5'd4;
    localparam excCode excAdES  = 5'd5;

    // Request to the pipeline controller
    typedef enum logic [1:0] {
        kernelNone   = 2'd0,
        kernelEntry  = 2'd1,
        kernelReturn = 2'd2
    } kernelOp;

    // Bundle from execute
    typedef struct packed {
        memOp        op;
        logic [31:0] pc;
        excCode      exc;
        logic [31:0] aluOut;
        logic [31:0] rtData;
        logic [4:0]  rtAddr;
        logic [4:0]  rdAddr;
        logic [4:0]  regWriteAddr;
        logic [31:0] regWriteData;
        logic [1:0]  tNew;
    } memInstr;

    // Word-addressed bus with byte lanes
    typedef struct packed {
        logic [29:0] wordAddr;
        logic [3:0]  byteEn;
        logic [31:0] wData;
    } memBusReq;

    // Bundle toward write-back
    typedef struct packed {
        memOp        op;
        logic [31:0] pc;
        logic [31:0] memWord;
        logic [1:0]  offset;
        logic [4:0]  regWriteAddr;
        logic [31:0] regWriteData;
        logic [1:0]  tNew;
    } wbBundle;

endpackage

/* rtl/memAccessCheck.sv */
// Memory access lane and address check
`include "memStage_settings.svh"

module memAccessCheck (
    input  memStagePkg::memOp     op,
    input  logic [31:0]           addr,
    input  logic [31:0]           wData,
    output memStagePkg::memBusReq busReq,
    output logic [1:0]            offset,
    output memStagePkg::excCode   excOut
);

    logic isLoad;
    logic isStore;
    logic isWord;
    logic isHalf;
    logic isByte;
    logic inData;
    logic inTimer;
    logic isCount;
    logic fault;

    always_comb begin
        isLoad  = op inside {memStagePkg::opLw, memStagePkg::opLh, memStagePkg::opLhu,
                             memStagePkg::opLb, memStagePkg::opLbu};
        isStore = op inside {memStagePkg::opSw, memStagePkg::opSh, memStagePkg::opSb};
        isWord  = op inside {memStagePkg::opLw, memStagePkg::opSw};
        isHalf  = op inside {memStagePkg::opLh, memStagePkg::opLhu, memStagePkg::opSh};
        isByte  = op inside {memStagePkg::opLb, memStagePkg::opLbu, memStagePkg::opSb};

        // Single unsigned compare per window
        inData  = (addr - `DM_START) < (`DM_END - `DM_START);
        inTimer = ((addr - `TIMER0_START) < (`TIMER0_END - `TIMER0_START)) ||
                  ((addr - `TIMER1_START) < (`TIMER1_END - `TIMER1_START));
        isCount = (addr == `TIMER0_COUNT) || (addr == `TIMER1_COUNT);
    end

    assign offset = addr[1:0];

    // Lane enables and store data placement
    always_comb begin
        busReq.wordAddr = addr[31:2];
        busReq.byteEn   = 4'b0000;
        busReq.wData    = wData;
        case (op)
            memStagePkg::opSw: begin
                busReq.byteEn = 4'b1111;
            end
            memStagePkg::opSh: begin
                busReq.byteEn = addr[1] ? 4'b1100 : 4'b0011;
                busReq.wData  = wData << {addr[1], 4'b0000};
            end
            memStagePkg::opSb: begin
                busReq.byteEn = 4'b0001 << addr[1:0];
                busReq.wData  = wData << {addr[1:0], 3'b000};
            end
            default: begin
                busReq.byteEn = 4'b0000;
            end
        endcase
    end

    // Address errors
    always_comb begin
        fault = 1'b0;
        if (isWord && addr[1:0] != 2'b00)
            fault = 1'b1;
        if (isHalf && addr[0])
            fault = 1'b1;
        // Timer registers only take whole words
        if ((isHalf || isByte) && !inData)
            fault = 1'b1;
        if (!inData && !inTimer)
            fault = 1'b1;
        if (isStore && isCount)
            fault = 1'b1;

        if (fault && isStore)
            excOut = memStagePkg::excAdES;
        else if (fault && isLoad)
            excOut = memStagePkg::excAdEL;
        else
            excOut = memStagePkg::excNone;
    end

endmodule

/* rtl/coprocessor0.sv */
// Coprocessor 0 system registers
`include "memStage_settings.svh"

module coprocessor0 (
    input  logic                 clk,
    input  logic                 reset,
    input  memStagePkg::memOp    op,
    input  logic [4:0]           regId,
    input  logic [31:0]          wData,
    input  logic [31:0]          pc,
    input  logic                 inDelaySlot,
    input  logic [5:0]           hwInt,
    input  memStagePkg::excCode  exc,
    output memStagePkg::kernelOp kernelCtrl,
    output logic [29:0]          exceptionPc,
    output logic                 excInDelaySlot,
    output logic [31:0]          readData
);

    // Status fields
    logic [5:0]  im;
    logic        exl;
    logic        ie;

    // Cause fields
    logic [5:0]  ip;
    logic [4:0]  excField;
    logic        bd;

    logic [31:0] epc;
    logic [31:0] epcNext;
    logic [31:0] srWord;
    logic [31:0] causeWord;
    logic        interrupt;
    logic        entry;
    logic        isEret;

    assign srWord    = {16'b0, im, 8'b0, exl, ie};
    assign causeWord = {bd, 15'b0, ip, 3'b0, excField, 2'b00};

    // Interrupts are held off inside the handler
    assign interrupt = (|(im & hwInt)) && ie && !exl;
    assign entry     = interrupt || (exc != memStagePkg::excNone);
    assign isEret    = (op == memStagePkg::opEret);

    // Return to the branch when the fault sits in its delay slot
    assign epcNext = (inDelaySlot ? pc - 32'd4 : pc) & 32'hFFFF_FFFC;

    always_comb begin
        if (entry)
            kernelCtrl = memStagePkg::kernelEntry;
        else if (isEret)
            kernelCtrl = memStagePkg::kernelReturn;
        else
            kernelCtrl = memStagePkg::kernelNone;
    end

    assign exceptionPc    = entry ? epcNext[31:2] : epc[31:2];
    assign excInDelaySlot = entry ? inDelaySlot : 1'b0;

    // mfc0 read port
    always_comb begin
        readData = 32'd0;
        if (op == memStagePkg::opMfc0) begin
            case (regId)
                `CP0_SR:    readData = srWord;
                `CP0_CAUSE: readData = causeWord;
                `CP0_EPC:   readData = epc;
                `CP0_PRID:  readData = `PRID_VALUE;
                default:    readData = 32'd0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            im       <= 6'b111111;
            exl      <= 1'b0;
            ie       <= 1'b1;
            ip       <= 6'b000000;
            excField <= 5'd0;
            bd       <= 1'b0;
            epc      <= `EPC_RESET;
        end else begin
            // Pending lines are sampled every cycle
            ip <= hwInt;
            if (entry) begin
                exl      <= 1'b1;
                excField <= interrupt ? memStagePkg::excNone : exc;
                bd       <= inDelaySlot;
                epc      <= epcNext;
            end else if (isEret) begin
                exl      <= 1'b0;
                excField <= 5'd0;
                bd       <= 1'b0;
            end else if (op == memStagePkg::opMtc0) begin
                if (regId == `CP0_SR)
                    {im, exl, ie} <= {wData[15:10], wData[1], wData[0]};
                else if (regId == `CP0_EPC)
                    epc <= {wData[31:2], 2'b00};
            end
        end
    end

endmodule

/* rtl/dataMemory.sv */
// Byte-lane data RAM
`include "memStage_settings.svh"

module dataMemory (
    input  logic                 clk,
    input  logic                 reset,
    input  memStagePkg::memBusReq req,
    output logic [31:0]          rData
);

    localparam int IdxBits = $clog2(`DM_WORDS);
    localparam logic [31:0] BaseAddr = `DM_START;

    logic [31:0]        mem [`DM_WORDS];
    logic [29:0]        wordOffset;
    logic [IdxBits-1:0] idx;
    logic               inRange;

    // Word index relative to the window base
    assign wordOffset = req.wordAddr - BaseAddr[31:2];
    assign idx        = wordOffset[IdxBits-1:0];
    assign inRange    = wordOffset < `DM_WORDS;

    assign rData = inRange ? mem[idx] : 32'd0;

    // No writes land while reset is held
    always_ff @(posedge clk) begin
        if (!reset && inRange) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req.byteEn[lane])
                    mem[idx][8*lane +: 8] <= req.wData[8*lane +: 8];
            end
        end
    end

endmodule

/* rtl/memStage.sv */
// Memory access pipeline stage
`include "memStage_settings.svh"

module memStage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  clr,
    input  memStagePkg::memInstr  memIn,
    input  logic [4:0]            wbAddr,
    input  logic [31:0]           wbData,
    input  logic                  inDelaySlot,
    input  logic [5:0]            hwInt,
    input  logic [31:0]           devRData,
    output memStagePkg::wbBundle  wbOut,
    output memStagePkg::memBusReq devReq,
    output memStagePkg::kernelOp  kernelCtrl,
    output logic [29:0]           exceptionPc,
    output logic                  excInDelaySlot
);

    logic [31:0]           fwdData;
    memStagePkg::memBusReq checkReq;
    memStagePkg::memBusReq dmReq;
    logic [1:0]            offset;
    memStagePkg::excCode   checkExc;
    memStagePkg::excCode   effExc;
    logic [31:0]           cp0Data;
    logic [31:0]           dmRData;
    logic [31:0]           loadWord;
    logic                  inData;
    logic                  inTimer;
    logic                  writeAllowed;
    logic                  isLoad;
    memStagePkg::wbBundle  wbNext;

    // Store operand forwarded from write-back, r0 never forwards
    assign fwdData = (wbAddr == memIn.rtAddr && wbAddr != 5'd0) ? wbData : memIn.rtData;

    memAccessCheck u_check (
        .op     (memIn.op),
        .addr   (memIn.aluOut),
        .wData  (fwdData),
        .busReq (checkReq),
        .offset (offset),
        .excOut (checkExc)
    );

    // Older exception from earlier stages wins
    assign effExc = (memIn.exc != memStagePkg::excNone) ? memIn.exc : checkExc;

    coprocessor0 u_cp0 (
        .clk            (clk),
        .reset          (reset),
        .op             (memIn.op),
        .regId          (memIn.rdAddr),
        .wData          (fwdData),
        .pc             (memIn.pc),
        .inDelaySlot    (inDelaySlot),
        .hwInt          (hwInt),
        .exc            (effExc),
        .kernelCtrl     (kernelCtrl),
        .exceptionPc    (exceptionPc),
        .excInDelaySlot (excInDelaySlot),
        .readData       (cp0Data)
    );

    // Window decode for routing
    assign inData  = (memIn.aluOut - `DM_START) < (`DM_END - `DM_START);
    assign inTimer = ((memIn.aluOut - `TIMER0_START) < (`TIMER0_END - `TIMER0_START)) ||
                     ((memIn.aluOut - `TIMER1_START) < (`TIMER1_END - `TIMER1_START));

    // A store that traps must not reach memory
    assign writeAllowed = (kernelCtrl != memStagePkg::kernelEntry);

    always_comb begin
        dmReq         = checkReq;
        dmReq.byteEn  = (inData && writeAllowed) ? checkReq.byteEn : 4'b0000;
        devReq        = checkReq;
        devReq.byteEn = (inTimer && writeAllowed) ? checkReq.byteEn : 4'b0000;
    end

    dataMemory u_mem (
        .clk   (clk),
        .reset (reset),
        .req   (dmReq),
        .rData (dmRData)
    );

    assign loadWord = inTimer ? devRData : dmRData;
    assign isLoad   = memIn.op inside {memStagePkg::opLw, memStagePkg::opLh,
                                       memStagePkg::opLhu, memStagePkg::opLb,
                                       memStagePkg::opLbu};

    // Write-back bundle
    always_comb begin
        wbNext.op           = memIn.op;
        wbNext.pc           = memIn.pc;
        wbNext.memWord      = loadWord;
        wbNext.offset       = offset;
        wbNext.regWriteAddr = memIn.regWriteAddr;
        if (memIn.op == memStagePkg::opMfc0)
            wbNext.regWriteData = cp0Data;
        else if (isLoad)
            wbNext.regWriteData = loadWord;
        else
            wbNext.regWriteData = memIn.regWriteData;
        // One stage closer to its result, floor at zero
        wbNext.tNew = (memIn.tNew != 2'd0) ? memIn.tNew - 2'd1 : 2'd0;
    end

    always_ff @(posedge clk) begin
        if (reset || clr)
            wbOut <= '0;
        else if (!stall)
            wbOut <= wbNext;
    end

endmodule

/* bench/memStageTb.sv */
// Memory stage testbench
`include "memStage_settings.svh"

module memStageTb;

    localparam int MaxCycles = 1000;
    localparam int NumAddrs  = 6;

    logic                  clk;
    logic                  reset;
    logic                  stall;
    logic                  clr;
    memStagePkg::memInstr  memIn;
    logic [4:0]            wbAddr;
    logic [31:0]           wbData;
    logic                  inDelaySlot;
    logic [5:0]            hwInt;
    logic [31:0]           devRData;
    memStagePkg::wbBundle  wbOut;
    memStagePkg::memBusReq devReq;
    memStagePkg::kernelOp  kernelCtrl;
    logic [29:0]           exceptionPc;
    logic                  excInDelaySlot;

    // Expectations checked at the next falling edge
    logic                  chkKernel;
    memStagePkg::kernelOp  expKernel;
    logic                  chkEpc;
    logic [29:0]           expEpc;
    logic                  chkDelaySlot;
    logic                  expDelaySlot;
    logic                  chkWbData;
    logic [31:0]           expWbData;
    logic                  chkOffset;
    logic [1:0]            expOffset;
    logic                  chkCause;
    logic [4:0]            expCode;
    logic                  expBd;
    logic                  chkTNew;
    logic [1:0]            expTNew;
    logic                  chkWbZero;
    logic                  chkHold;
    memStagePkg::wbBundle  heldWb;
    logic                  chkNoWrite;
    logic                  chkDev;
    logic [3:0]            expDevEn;
    logic [31:0]           expDevData;

    int                    errorCount;
    int                    testErrors;
    int                    testsRun;
    int                    testsFailed;
    int                    cycleCount;
    logic [15:0]           lfsrState;
    logic [31:0]           pcNext;
    logic [31:0]           addrList [NumAddrs];
    logic [31:0]           shadow [`DM_WORDS];

    memStage u_dut (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .clr            (clr),
        .memIn          (memIn),
        .wbAddr         (wbAddr),
        .wbData         (wbData),
        .inDelaySlot    (inDelaySlot),
        .hwInt          (hwInt),
        .devRData       (devRData),
        .wbOut          (wbOut),
        .devReq         (devReq),
        .kernelCtrl     (kernelCtrl),
        .exceptionPc    (exceptionPc),
        .excInDelaySlot (excInDelaySlot)
    );

    always #5 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic reportError(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        errorCount++;
    endtask

    kernelOk: assert property (@(negedge clk) !chkKernel || kernelCtrl == expKernel)
        else reportError($sformatf("kernelCtrl %0d, expected %0d", kernelCtrl, expKernel));
    epcOk: assert property (@(negedge clk) !chkEpc || exceptionPc == expEpc)
        else reportError($sformatf("exceptionPc %h, expected %h", exceptionPc, expEpc));
    delaySlotOk: assert property (@(negedge clk) !chkDelaySlot || excInDelaySlot == expDelaySlot)
        else reportError($sformatf("excInDelaySlot %0d, expected %0d",
                                   excInDelaySlot, expDelaySlot));
    wbDataOk: assert property (@(negedge clk) !chkWbData || wbOut.regWriteData == expWbData)
        else reportError($sformatf("regWriteData %h, expected %h",
                                   wbOut.regWriteData, expWbData));
    offsetOk: assert property (@(negedge clk) !chkOffset || wbOut.offset == expOffset)
        else reportError($sformatf("offset %0d, expected %0d", wbOut.offset, expOffset));
    // Cause holds BD in bit 31 and ExcCode in bits 6:2
    causeOk: assert property (@(negedge clk) !chkCause ||
                              (wbOut.regWriteData[6:2] == expCode &&
                               wbOut.regWriteData[31] == expBd))
        else reportError($sformatf("Cause %h, expected code %0d bd %0d",
                                   wbOut.regWriteData, expCode, expBd));
    tNewOk: assert property (@(negedge clk) !chkTNew || wbOut.tNew == expTNew)
        else reportError($sformatf("tNew %0d, expected %0d", wbOut.tNew, expTNew));
    zeroOk: assert property (@(negedge clk) !chkWbZero || wbOut == '0)
        else reportError("wbOut not cleared");
    holdOk: assert property (@(negedge clk) !chkHold || wbOut == heldWb)
        else reportError("wbOut changed during stall");
    noWriteOk: assert property (@(negedge clk) !chkNoWrite ||
                                (devReq.byteEn == 4'b0000 && u_dut.dmReq.byteEn == 4'b0000))
        else reportError("byte enables active on a faulting access");
    devOk: assert property (@(negedge clk) !chkDev ||
                            (devReq.byteEn == expDevEn && devReq.wData == expDevData))
        else reportError($sformatf("devReq enables %b data %h, expected %b %h",
                                   devReq.byteEn, devReq.wData, expDevEn, expDevData));

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit
    task automatic randomBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic clearChecks();
        chkKernel    = 1'b0;
        chkEpc       = 1'b0;
        chkDelaySlot = 1'b0;
        chkWbData    = 1'b0;
        chkOffset    = 1'b0;
        chkCause     = 1'b0;
        chkTNew      = 1'b0;
        chkWbZero    = 1'b0;
        chkHold      = 1'b0;
        chkNoWrite   = 1'b0;
        chkDev       = 1'b0;
    endtask

    task automatic issue(input memStagePkg::memOp op, input logic [31:0] addr,
                         input logic [31:0] data);
        clearChecks();
        memIn        = '0;
        memIn.op     = op;
        memIn.pc     = pcNext;
        memIn.aluOut = addr;
        memIn.rtData = data;
        pcNext       = pcNext + 32'd4;
    endtask

    // Lane rule applied to the shadow copy
    task automatic applyStore(input memStagePkg::memOp op, input logic [31:0] addr,
                              input logic [31:0] data);
        logic [11:0] idx;
        idx = addr[13:2];
        case (op)
            memStagePkg::opSw: shadow[idx] = data;
            memStagePkg::opSh: begin
                if (addr[1])
                    shadow[idx][31:16] = data[15:0];
                else
                    shadow[idx][15:0] = data[15:0];
            end
            default: shadow[idx][8*addr[1:0] +: 8] = data[7:0];
        endcase
    endtask

    task automatic doStore(input memStagePkg::memOp op, input logic [31:0] addr,
                           input logic [31:0] data);
        issue(op, addr, data);
        applyStore(op, addr, data);
        chkKernel = 1'b1;
        expKernel = memStagePkg::kernelNone;
        nextCycle();
    endtask

    // Word load, then a byte load at the given lane of the same word
    task automatic checkLoad(input logic [31:0] addr, input logic [1:0] lane);
        issue(memStagePkg::opLw, addr, 32'd0);
        nextCycle();
        issue(memStagePkg::opLbu, addr + lane, 32'd0);
        chkWbData = 1'b1;
        expWbData = shadow[addr[13:2]];
        chkOffset = 1'b1;
        expOffset = addr[1:0];
        nextCycle();
        issue(memStagePkg::opNone, 32'd0, 32'd0);
        chkWbData = 1'b1;
        expWbData = shadow[addr[13:2]];
        chkOffset = 1'b1;
        expOffset = lane;
        nextCycle();
    endtask

    // Fault, read Cause, then return
    task automatic addressFault(input memStagePkg::memOp op, input logic [31:0] addr,
                                input logic [4:0] code);
        issue(op, addr, 32'hDEAD_BEEF);
        chkKernel  = 1'b1;
        expKernel  = memStagePkg::kernelEntry;
        chkEpc     = 1'b1;
        expEpc     = memIn.pc[31:2];
        chkNoWrite = 1'b1;
        nextCycle();
        issue(memStagePkg::opMfc0, 32'd0, 32'd0);
        memIn.rdAddr = `CP0_CAUSE;
        chkKernel    = 1'b1;
        expKernel    = memStagePkg::kernelNone;
        nextCycle();
        issue(memStagePkg::opEret, 32'd0, 32'd0);
        chkKernel = 1'b1;
        expKernel = memStagePkg::kernelReturn;
        chkCause  = 1'b1;
        expCode   = code;
        expBd     = 1'b0;
        nextCycle();
    endtask

    task automatic startTest();
        testErrors = errorCount;
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errorCount == testErrors) begin
            $display("Test %s: ok", name);
        end else begin
            testsFailed++;
            $display("Test %s: FAILED with %0d errors", name, errorCount - testErrors);
        end
    endtask

    initial begin
        logic [31:0]       r;
        logic [31:0]       data;
        logic [31:0]       addr;
        logic [31:0]       intPc;
        int                pick;
        memStagePkg::memOp op;
        clk         = 1'b0;
        reset       = 1'b1;
        stall       = 1'b0;
        clr         = 1'b0;
        memIn       = '0;
        wbAddr      = 5'd0;
        wbData      = 32'd0;
        inDelaySlot = 1'b0;
        hwInt       = 6'd0;
        devRData    = 32'h0BAD_F00D;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        cycleCount  = 0;
        lfsrState   = 16'd92;
        pcNext      = 32'h0000_3000;
        clearChecks();
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        startTest();
        issue(memStagePkg::opMfc0, 32'd0, 32'd0);
        memIn.rdAddr = `CP0_SR;
        chkWbZero    = 1'b1;
        chkKernel    = 1'b1;
        expKernel    = memStagePkg::kernelNone;
        chkDelaySlot = 1'b1;
        expDelaySlot = 1'b0;
        nextCycle();
        issue(memStagePkg::opMfc0, 32'd0, 32'd0);
        memIn.rdAddr = `CP0_PRID;
        chkWbData    = 1'b1;
        // IM all ones in bits 15:10 and IE in bit 0
        expWbData    = 32'h0000_FC01;
        nextCycle();
        issue(memStagePkg::opNone, 32'd0, 32'd0);
        chkWbData = 1'b1;
        expWbData = `PRID_VALUE;
        nextCycle();
        endTest("reset state");

        startTest();
        for (int i = 0; i < NumAddrs; i++) begin
            randomBits(12, r);
            addrList[i] = (r % `DM_WORDS) * 4;
            randomBits(32, data);
            doStore(memStagePkg::opSw, addrList[i], data);
        end
        for (int n = 0; n < 12; n++) begin
            randomBits(3, r);
            pick = r % NumAddrs;
            addr = addrList[pick];
            randomBits(2, r);
            if (r[1:0] == 2'd0) begin
                op = memStagePkg::opSw;
            end else if (r[1:0] == 2'd1) begin
                op = memStagePkg::opSh;
                randomBits(1, r);
                addr = addr + {r[0], 1'b0};
            end else begin
                op = memStagePkg::opSb;
                randomBits(2, r);
                addr = addr + r[1:0];
            end
            randomBits(32, data);
            doStore(op, addr, data);
        end
        for (int i = 0; i < NumAddrs; i++)
            checkLoad(addrList[i], i[1:0]);
        endTest("byte lanes");

        startTest();
        addressFault(memStagePkg::opLw, 32'h0000_0102, 5'd4);
        addressFault(memStagePkg::opLb, 32'h0000_7F04, 5'd4);
        addressFault(memStagePkg::opSw, `TIMER1_COUNT, 5'd5);
        checkLoad(addrList[0], 2'd3);
        endTest("address errors");

        startTest();
        issue(memStagePkg::opSw, `TIMER0_START, 32'h1357_9BDF);
        chkKernel  = 1'b1;
        expKernel  = memStagePkg::kernelNone;
        chkDev     = 1'b1;
        expDevEn   = 4'b1111;
        expDevData = 32'h1357_9BDF;
        nextCycle();
        issue(memStagePkg::opLw, `TIMER0_START + 32'd4, 32'd0);
        nextCycle();
        issue(memStagePkg::opNone, 32'd0, 32'd0);
        chkWbData = 1'b1;
        expWbData = devRData;
        nextCycle();
        endTest("device port");

        startTest();
        issue(memStagePkg::opNone, 32'd0, 32'd0);
        intPc        = memIn.pc;
        inDelaySlot  = 1'b1;
        hwInt        = 6'b000100;
        chkKernel    = 1'b1;
        expKernel    = memStagePkg::kernelEntry;
        chkEpc       = 1'b1;
        expEpc       = intPc[31:2] - 30'd1;
        chkDelaySlot = 1'b1;
        expDelaySlot = 1'b1;
        nextCycle();
        // EXL now set so a new request is ignored
        issue(memStagePkg::opMfc0, 32'd0, 32'd0);
        memIn.rdAddr = `CP0_CAUSE;
        inDelaySlot  = 1'b0;
        hwInt        = 6'b000001;
        chkKernel    = 1'b1;
        expKernel    = memStagePkg::kernelNone;
        nextCycle();
        issue(memStagePkg::opMfc0, 32'd0, 32'd0);
        memIn.rdAddr = `CP0_EPC;
        hwInt        = 6'd0;
        chkCause     = 1'b1;
        expCode      = 5'd0;
        expBd        = 1'b1;
        nextCycle();
        issue(memStagePkg::opEret, 32'd0, 32'd0);
        chkWbData = 1'b1;
        expWbData = intPc - 32'd4;
        chkKernel = 1'b1;
        expKernel = memStagePkg::kernelReturn;
        nextCycle();
        issue(memStagePkg::opMtc0, 32'd0, 32'h0000_0001);
        memIn.rdAddr = `CP0_SR;
        chkKernel    = 1'b1;
        expKernel    = memStagePkg::kernelNone;
        nextCycle();
        issue(memStagePkg::opNone, 32'd0, 32'd0);
        hwInt        = 6'b111111;
        inDelaySlot  = 1'b1;
        chkKernel    = 1'b1;
        expKernel    = memStagePkg::kernelNone;
        chkDelaySlot = 1'b1;
        expDelaySlot = 1'b0;
        nextCycle();
        issue(memStagePkg::opMtc0, 32'd0, 32'h0000_FC01);
        memIn.rdAddr = `CP0_SR;
        hwInt        = 6'd0;
        inDelaySlot  = 1'b0;
        nextCycle();
        endTest("interrupts");

        startTest();
        issue(memStagePkg::opSw, addrList[0], 32'h1111_1111);
        memIn.rtAddr = 5'd5;
        wbAddr       = 5'd5;
        wbData       = 32'hA5A5_0F0F;
        applyStore(memStagePkg::opSw, addrList[0], wbData);
        nextCycle();
        wbAddr = 5'd0;
        wbData = 32'd0;
        checkLoad(addrList[0], 2'd1);
        issue(memStagePkg::opSw, addrList[1], 32'h2222_3333);
        wbData = 32'h7777_7777;
        applyStore(memStagePkg::opSw, addrList[1], 32'h2222_3333);
        nextCycle();
        wbData = 32'd0;
        checkLoad(addrList[1], 2'd2);
        endTest("forwarding");

        startTest();
        issue(memStagePkg::opNone, 32'd0, 32'd0);
        memIn.regWriteData = 32'hCAFE_0001;
        memIn.tNew         = 2'd2;
        nextCycle();
        issue(memStagePkg::opNone, 32'd0, 32'd0);
        memIn.regWriteData = 32'hCAFE_0002;
        chkTNew            = 1'b1;
        expTNew            = 2'd1;
        chkWbData          = 1'b1;
        expWbData          = 32'hCAFE_0001;
        heldWb             = wbOut;
        stall              = 1'b1;
        nextCycle();
        chkHold = 1'b1;
        stall   = 1'b0;
        nextCycle();
        clearChecks();
        chkTNew   = 1'b1;
        expTNew   = 2'd0;
        chkWbData = 1'b1;
        expWbData = 32'hCAFE_0002;
        clr       = 1'b1;
        nextCycle();
        issue(memStagePkg::opNone, 32'd0, 32'd0);
        clr       = 1'b0;
        chkWbZero = 1'b1;
        nextCycle();
        endTest("pipeline control");

        $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* memStage.f */
+incdir+rtl
rtl/memStagePkg.sv
rtl/memAccessCheck.sv
rtl/coprocessor0.sv
rtl/dataMemory.sv
rtl/memStage.sv
bench/memStageTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = memStageTb
FILELIST  = memStage.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
